// ==== cache_sub.f ====
rtl/cache_cfg_pkg.sv
rtl/cache_bus_pkg.sv
rtl/lru.sv
rtl/tag_ram.sv
rtl/data_ram.sv
rtl/refill_ctrl.sv
rtl/cache_top.sv
tests/tb_cache_top.sv

// ==== tests/tb_cache_top.sv ====
module tb_cache_top import cache_cfg_pkg::*, cache_bus_pkg::*; ();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int random_requests   = 400;
    localparam int directed_requests = 26;
    localparam int cycle_limit       = (random_requests + directed_requests) * 40 + 10;

    logic      clk;
    logic      rst_n;
    logic      cache_en;
    logic      req_valid;
    cpu_req_t  req;
    logic      busy;
    logic      rsp_valid;
    cpu_rsp_t  rsp;
    logic      mem_rd_en;
    mem_req_t  mem_req;
    logic      mem_fill_valid;
    mem_fill_t mem_fill;

    integer seed = 72561;
    int     error_count = 0;
    int     fill_delay = 0;  // Latency of the last memory fetch in cycles.
    int     cycle_count;

    logic [tag_width-1:0] model_tag   [line_num][way_num];
    bit                   model_valid [line_num][way_num];
    int                   model_age   [line_num][way_num];

    cache_top UUT (
        .clk            (clk),
        .rst_n          (rst_n),
        .cache_en       (cache_en),
        .req_valid      (req_valid),
        .req            (req),
        .busy           (busy),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .mem_rd_en      (mem_rd_en),
        .mem_req        (mem_req),
        .mem_fill_valid (mem_fill_valid),
        .mem_fill       (mem_fill)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic stop_with_failure();
        $display("Checks failed");
        $fatal(1, "Simulation stopped at the first error.");
    endtask

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            error_count++;
            $display("FAILED at %0t ns: %s is %h, expected %h", $time, name, actual, expected);
            stop_with_failure();
        end
    endtask

    initial begin
        cycle_count = 0;
        while (cycle_count < cycle_limit) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout: the tests did not finish within %0d cycles.", cycle_limit);
        stop_with_failure();
    end

    function automatic logic [word_bits-1:0] word_at(input logic [addr_width-1:0] addr);
        return {addr[addr_width-1:2], 2'b00} ^ 32'hC0DE_0000;
    endfunction

    // Main memory answers each fetch once, after 1 to 8 cycles.
    initial begin
        logic [addr_width-1:0] line_addr;
        mem_fill_valid = 1'b0;
        mem_fill       = '0;
        forever begin
            @(posedge clk);
            #10;
            if (mem_rd_en) begin
                line_addr  = mem_req.addr;
                fill_delay = 1 + ($unsigned($random(seed)) % 8);
                repeat (fill_delay) @(posedge clk);
                #10;
                for (int i = 0; i < line_bits / word_bits; i++) begin
                    mem_fill.line[i*word_bits +: word_bits] = word_at(line_addr + 32'(4 * i));
                end
                mem_fill_valid = 1'b1;
                @(posedge clk);
                #10;
                mem_fill_valid = 1'b0;
            end
        end
    end

    function automatic int find_way(input logic [index_width-1:0] idx,
                                    input logic [tag_width-1:0] t);
        int way;
        way = -1;
        for (int w = 0; w < way_num; w++) begin
            if (model_valid[idx][w] && model_tag[idx][w] == t) begin
                way = w;
            end
        end
        return way;
    endfunction

    // Lowest empty way, otherwise the oldest one.
    function automatic int victim_way(input logic [index_width-1:0] idx);
        int way;
        way = -1;
        for (int w = 0; w < way_num; w++) begin
            if (way < 0 && !model_valid[idx][w]) begin
                way = w;
            end
        end
        for (int w = 0; w < way_num; w++) begin
            if (way < 0 && model_age[idx][w] == way_num - 1) begin
                way = w;
            end
        end
        return way;
    endfunction

    // A new line counts as the oldest way before it becomes the newest.
    function automatic void touch_way(input logic [index_width-1:0] idx, input int way,
                                      input bit was_valid);
        int prior;
        prior = was_valid ? model_age[idx][way] : way_num - 1;
        for (int w = 0; w < way_num; w++) begin
            if (w != way && model_valid[idx][w] && model_age[idx][w] < prior) begin
                model_age[idx][w]++;
            end
        end
        model_age[idx][way] = 0;
    endfunction

    task automatic run_request(input logic [addr_width-1:0] addr, input logic en,
                               output bit hit_seen);
        logic [tag_width-1:0]   t;
        logic [index_width-1:0] idx;
        int                     way;
        bit                     was_valid;
        int                     cycles;
        int                     reads;
        int                     read_cycle;
        logic [addr_width-1:0]  fetch_addr;
        t          = addr[addr_width-1 -: tag_width];
        idx        = addr[offset_width +: index_width];
        way        = en ? find_way(idx, t) : -1;
        cycles     = 0;
        reads      = 0;
        read_cycle = 0;
        fetch_addr = '0;
        check_value("busy before request", busy, 1'b0);
        req_valid = 1'b1;
        req.addr  = addr;
        cache_en  = en;
        do begin
            @(posedge clk);
            #10;
            cycles++;
            if (cycles == 1) begin
                req_valid = 1'b0;
                check_value("busy in lookup", busy, 1'b1);
            end
            if (mem_rd_en) begin
                reads++;
                read_cycle = cycles;
                fetch_addr = mem_req.addr;
            end
        end while (!rsp_valid);
        hit_seen = (reads == 0);
        check_value("busy at response", busy, 1'b0);
        check_value("rsp.data", rsp.data, word_at(addr));
        if (way >= 0) begin
            check_value("mem_rd_en count", reads, 0);
            check_value("rsp_valid cycle", cycles, 2);
            touch_way(idx, way, 1'b1);
        end else begin
            check_value("mem_rd_en count", reads, 1);
            check_value("mem_rd_en cycle", read_cycle, 2);
            check_value("mem_req.addr", fetch_addr, addr & ~32'h0000_000F);
            check_value("rsp_valid cycle", cycles, read_cycle + fill_delay + (en ? 2 : 1));
            if (en) begin
                way       = victim_way(idx);
                was_valid = model_valid[idx][way];
                model_valid[idx][way] = 1'b1;
                model_tag[idx][way]   = t;
                touch_way(idx, way, was_valid);
            end
        end
    endtask

    initial begin
        bit                      hit_seen;
        logic [tag_width-1:0]    set_tags [4];
        logic [tag_width-1:0]    evicted_tag;
        logic [tag_width-1:0]    rtag;
        logic [index_width-1:0]  ridx;
        logic [offset_width-1:0] roff;
        bit                      ren;
        int                      victim;
        int                      hits;
        hits      = 0;
        rst_n     = 1'b0;
        cache_en  = 1'b1;
        req_valid = 1'b0;
        req       = '0;
        for (int s = 0; s < line_num; s++) begin
            for (int w = 0; w < way_num; w++) begin
                model_valid[s][w] = 1'b0;
                model_tag[s][w]   = '0;
                model_age[s][w]   = 0;
            end
        end
        repeat (3) @(posedge clk);
        #10;
        rst_n = 1'b1;
        check_value("busy after reset", busy, 1'b0);
        check_value("rsp_valid after reset", rsp_valid, 1'b0);
        check_value("mem_rd_en after reset", mem_rd_en, 1'b0);

        run_request({24'h12_3456, 4'd0, 4'h8}, 1'b1, hit_seen);
        check_value("first request hit", hit_seen, 1'b0);
        run_request({24'h12_3456, 4'd0, 4'h8}, 1'b1, hit_seen);
        check_value("repeated request hit", hit_seen, 1'b1);
        run_request({24'h12_3456, 4'd0, 4'hC}, 1'b1, hit_seen);
        check_value("same line hit", hit_seen, 1'b1);

        set_tags = '{24'hA0_0001, 24'hB1_0002, 24'hC2_0003, 24'hD3_0004};
        for (int k = 0; k < 4; k++) begin
            run_request({set_tags[k], 4'd5, 4'(4 * k)}, 1'b1, hit_seen);
            check_value("set fill hit", hit_seen, 1'b0);
        end
        foreach (set_tags[k]) begin
            run_request({set_tags[(k * 3 + 2) % 4], 4'd5, 4'h0}, 1'b1, hit_seen);
            check_value("filled set hit", hit_seen, 1'b1);
        end

        victim      = victim_way(4'd5);
        evicted_tag = model_tag[5][victim];
        run_request({24'hE4_0005, 4'd5, 4'h0}, 1'b1, hit_seen);
        check_value("fifth tag hit", hit_seen, 1'b0);
        for (int k = 0; k < 4; k++) begin
            if (set_tags[k] != evicted_tag) begin
                run_request({set_tags[k], 4'd5, 4'h4}, 1'b1, hit_seen);
                check_value("surviving tag hit", hit_seen, 1'b1);
            end
        end
        run_request({evicted_tag, 4'd5, 4'h8}, 1'b1, hit_seen);
        check_value("evicted tag hit", hit_seen, 1'b0);

        for (int k = 0; k < 4; k++) begin
            run_request({model_tag[5][k], 4'd5, 4'(4 * k)}, 1'b0, hit_seen);
        end
        run_request({24'hF5_0006, 4'd5, 4'h4}, 1'b0, hit_seen);
        for (int k = 0; k < 4; k++) begin
            run_request({model_tag[5][k], 4'd5, 4'(4 * k)}, 1'b1, hit_seen);
            check_value("hit after bypass", hit_seen, 1'b1);
        end
        run_request({24'hF5_0006, 4'd5, 4'h4}, 1'b1, hit_seen);
        check_value("bypassed line hit", hit_seen, 1'b0);

        // Six tags over four sets keep the ways under steady eviction.
        for (int n = 0; n < random_requests; n++) begin
            rtag = tag_width'(32'h005A_0000 + ($unsigned($random(seed)) % 6) * 32'h1111);
            ridx = index_width'($unsigned($random(seed)) % 4);
            roff = offset_width'($random(seed));
            ren  = ($unsigned($random(seed)) % 4) != 0;
            run_request({rtag, ridx, roff}, ren, hit_seen);
            hits += hit_seen;
        end
        $display("Random phase: %0d hits in %0d requests", hits, random_requests);

        if (error_count == 0) begin
            $display("All checks passed");
        end else begin
            $display("Checks failed");
        end
        $finish;
    end

endmodule

// ==== rtl/cache_top.sv ====
module cache_top import cache_cfg_pkg::*, cache_bus_pkg::*; (
    input  logic      clk,
    input  logic      rst_n,
    input  logic      cache_en,
    input  logic      req_valid,
    input  cpu_req_t  req,
    output logic      busy,
    output logic      rsp_valid,
    output cpu_rsp_t  rsp,
    output logic      mem_rd_en,
    output mem_req_t  mem_req,
    input  logic      mem_fill_valid,
    input  mem_fill_t mem_fill
);

    logic [tag_width-1:0]    tag;
    logic [index_width-1:0]  index;
    logic [offset_width-1:0] offset;
    logic                    lookup_en;
    logic                    fill_en;
    logic [addr_width-1:0]   refill_addr;
    logic [way_num-1:0]      hit_en;
    logic [way_num-1:0]      way_replace_en;
    logic [word_bits-1:0]    hit_word;

    refill_ctrl u_refill_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .cache_en       (cache_en),
        .req_valid      (req_valid),
        .req            (req),
        .busy           (busy),
        .rsp_valid      (rsp_valid),
        .rsp            (rsp),
        .mem_rd_en      (mem_rd_en),
        .mem_req        (mem_req),
        .mem_fill_valid (mem_fill_valid),
        .mem_fill       (mem_fill),
        .tag            (tag),
        .index          (index),
        .offset         (offset),
        .lookup_en      (lookup_en),
        .fill_en        (fill_en),
        .refill_addr    (refill_addr),
        .hit_en         (hit_en),
        .hit_word       (hit_word)
    );

    tag_ram u_tag_ram (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_en      (lookup_en),
        .tag            (tag),
        .index          (index),
        .hit_en         (hit_en),
        .fill_en        (fill_en),
        .refill_addr    (refill_addr),
        .way_replace_en (way_replace_en)
    );

    data_ram u_data_ram (
        .clk            (clk),
        .rst_n          (rst_n),
        .fill_en        (fill_en),
        .way_replace_en (way_replace_en),
        .index          (index),
        .offset         (offset),
        .hit_en         (hit_en),
        .fill_line      (mem_fill.line),  // Fill line goes straight into the store.
        .hit_word       (hit_word)
    );

endmodule

// ==== rtl/refill_ctrl.sv ====
module refill_ctrl import cache_cfg_pkg::*, cache_bus_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    cache_en,
    input  logic                    req_valid,
    input  cpu_req_t                req,
    output logic                    busy,
    output logic                    rsp_valid,
    output cpu_rsp_t                rsp,
    output logic                    mem_rd_en,
    output mem_req_t                mem_req,
    input  logic                    mem_fill_valid,
    input  mem_fill_t               mem_fill,
    output logic [tag_width-1:0]    tag,
    output logic [index_width-1:0]  index,
    output logic [offset_width-1:0] offset,
    output logic                    lookup_en,
    output logic                    fill_en,
    output logic [addr_width-1:0]   refill_addr,
    input  logic [way_num-1:0]      hit_en,
    input  logic [word_bits-1:0]    hit_word
);

    ctrl_state_e               state;
    logic                      cached_q;  // cache_en as seen with the request.
    logic [addr_width-1:0]     addr_q;
    logic                      hit;
    logic [offset_width-3:0]   word_idx;
    logic [word_bits-1:0]      fill_word;

    assign tag    = addr_q[addr_width-1 -: tag_width];
    assign index  = addr_q[offset_width +: index_width];
    assign offset = addr_q[offset_width-1:0];

    // The request is held for the whole miss, so the fetch address is stable too.
    assign refill_addr = {addr_q[addr_width-1:offset_width], {offset_width{1'b0}}};

    assign busy      = (state != idle);
    assign lookup_en = cached_q && (state == lookup || state == replay);
    assign fill_en   = cached_q && (state == wait_fill) && mem_fill_valid;
    assign hit       = |hit_en;

    assign word_idx  = offset[offset_width-1:2];
    assign fill_word = mem_fill.line[word_idx*word_bits +: word_bits];  // Bypass word.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= idle;
            cached_q  <= 1'b0;
            rsp_valid <= 1'b0;
            mem_rd_en <= 1'b0;
        end else begin
            rsp_valid <= 1'b0;
            mem_rd_en <= 1'b0;
            case (state)
                idle: begin
                    if (req_valid) begin
                        state    <= lookup;
                        cached_q <= cache_en;
                    end
                end
                lookup: begin
                    if (hit) begin
                        rsp_valid <= 1'b1;
                        state     <= idle;
                    end else begin
                        mem_rd_en <= 1'b1;  // A bypass request always lands here.
                        state     <= wait_fill;
                    end
                end
                wait_fill: begin
                    if (mem_fill_valid) begin
                        if (cached_q) begin
                            state <= replay;
                        end else begin
                            rsp_valid <= 1'b1;
                            state     <= idle;
                        end
                    end
                end
                replay: begin
                    rsp_valid <= 1'b1;  // The line was written in the fill cycle.
                    state     <= idle;
                end
                default: begin
                    state <= idle;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == idle && req_valid) begin
            addr_q <= req.addr;
        end
        if (state == lookup && !hit) begin
            mem_req.addr <= refill_addr;
        end
        if ((state == lookup && hit) || state == replay) begin
            rsp.data <= hit_word;
        end else if (state == wait_fill && mem_fill_valid && !cached_q) begin
            rsp.data <= fill_word;
        end
    end

endmodule

// ==== rtl/data_ram.sv ====
module data_ram import cache_cfg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    fill_en,
    input  logic [way_num-1:0]      way_replace_en,
    input  logic [index_width-1:0]  index,
    input  logic [offset_width-1:0] offset,
    input  logic [way_num-1:0]      hit_en,
    input  logic [line_bits-1:0]    fill_line,
    output logic [word_bits-1:0]    hit_word
);

    logic [line_bits-1:0]      line_mem [way_num][line_num];
    logic [line_num-1:0]       loaded_q [way_num];
    logic [line_bits-1:0]      hit_line;
    logic [offset_width-3:0]   word_idx;

    always_ff @(posedge clk) begin
        for (int w = 0; w < way_num; w++) begin
            if (fill_en && way_replace_en[w]) begin
                line_mem[w][index] <= fill_line;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int w = 0; w < way_num; w++) begin
                loaded_q[w] <= '0;
            end
        end else begin
            for (int w = 0; w < way_num; w++) begin
                if (fill_en && way_replace_en[w]) begin
                    loaded_q[w][index] <= 1'b1;
                end
            end
        end
    end

    // A line never written reads as zero.
    always_comb begin
        hit_line = '0;
        for (int w = 0; w < way_num; w++) begin
            if (hit_en[w] && loaded_q[w][index]) begin
                hit_line = line_mem[w][index];
            end
        end
    end

    assign word_idx = offset[offset_width-1:2];  // Byte lanes dropped.
    assign hit_word = hit_line[word_idx*word_bits +: word_bits];

endmodule

// ==== rtl/tag_ram.sv ====
module tag_ram import cache_cfg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lookup_en,
    input  logic [tag_width-1:0]    tag,
    input  logic [index_width-1:0]  index,
    output logic [way_num-1:0]      hit_en,
    input  logic                    fill_en,
    input  logic [addr_width-1:0]   refill_addr,
    output logic [way_num-1:0]      way_replace_en
);

    logic [tag_width-1:0]   tag_mem [way_num][line_num];
    logic [line_num-1:0]    valid_q [way_num];

    logic [tag_width-1:0]   fill_tag;
    logic [index_width-1:0] fill_index;
    logic [tag_width-1:0]   fill_tag_q;
    logic [index_width-1:0] fill_index_q;
    replace_way_e           victim_q;

    logic [way_num-1:0]     valid_vec;
    replace_way_e           replaced_way;

    assign fill_tag   = refill_addr[addr_width-1 -: tag_width];
    assign fill_index = refill_addr[offset_width +: index_width];

    // The refill target is taken one cycle late, well before any fill can return.
    always_ff @(posedge clk) begin
        fill_tag_q   <= fill_tag;
        fill_index_q <= fill_index;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            victim_q <= no_way;
            for (int w = 0; w < way_num; w++) begin
                valid_q[w] <= '0;
            end
        end else begin
            victim_q <= replaced_way;
            for (int w = 0; w < way_num; w++) begin
                if (fill_en && victim_q == replace_way_e'(w)) begin
                    valid_q[w][fill_index_q] <= 1'b1;  // The line becomes usable.
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < way_num; w++) begin
            if (fill_en && victim_q == replace_way_e'(w)) begin
                tag_mem[w][fill_index_q] <= fill_tag_q;
            end
        end
    end

    // Tag compare per way on the set addressed by the controller.
    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            valid_vec[w] = valid_q[w][index];
            hit_en[w]    = lookup_en && valid_vec[w] && (tag_mem[w][index] == tag);
        end
    end

    lru u_lru (
        .clk            (clk),
        .rst_n          (rst_n),
        .lookup_en      (lookup_en),
        .hit_en         (hit_en),
        .index          (index),
        .valid_vec      (valid_vec),
        .way_replace_en (way_replace_en),
        .replaced_way   (replaced_way)
    );

endmodule

// ==== rtl/lru.sv ====
module lru import cache_cfg_pkg::*; (
    input  logic                    clk,
    input  logic                    rst_n,
    input  logic                    lookup_en,
    input  logic [way_num-1:0]      hit_en,
    input  logic [index_width-1:0]  index,
    input  logic [way_num-1:0]      valid_vec,
    output logic [way_num-1:0]      way_replace_en,
    output replace_way_e            replaced_way
);

    logic [age_width-1:0] age_q [line_num][way_num];
    logic [age_width-1:0] hit_age;

    // Lowest invalid way first; a full set gives up its oldest way.
    always_comb begin
        replaced_way = no_way;
        if (&valid_vec) begin
            for (int w = way_num - 1; w >= 0; w--) begin
                if (age_q[index][w] == age_max) begin
                    replaced_way = replace_way_e'(w);
                end
            end
        end else begin
            for (int w = way_num - 1; w >= 0; w--) begin
                if (!valid_vec[w]) begin
                    replaced_way = replace_way_e'(w);
                end
            end
        end
    end

    always_comb begin
        for (int w = 0; w < way_num; w++) begin
            way_replace_en[w] = (replaced_way == replace_way_e'(w));
        end
    end

    always_comb begin
        hit_age = '0;
        for (int w = 0; w < way_num; w++) begin
            if (hit_en[w]) begin
                hit_age = age_q[index][w];
            end
        end
    end

    // Ways that hold no line yet are kept at the oldest age. A freshly filled
    // way then enters at the top and pushes every valid way one step older.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int s = 0; s < line_num; s++) begin
                for (int w = 0; w < way_num; w++) begin
                    age_q[s][w] <= '0;
                end
            end
        end else if (lookup_en && |hit_en) begin
            for (int w = 0; w < way_num; w++) begin
                if (hit_en[w]) begin
                    age_q[index][w] <= '0;  // Most recently used.
                end else if (!valid_vec[w]) begin
                    age_q[index][w] <= age_max;
                end else if (age_q[index][w] < hit_age) begin
                    age_q[index][w] <= age_q[index][w] + 1'b1;
                end
            end
        end
    end

endmodule

// ==== rtl/cache_bus_pkg.sv ====
package cache_bus_pkg;

    import cache_cfg_pkg::*;

    // CPU read request, a byte address.
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } cpu_req_t;

    // Word returned to the CPU.
    typedef struct packed {
        logic [word_bits-1:0] data;
    } cpu_rsp_t;

    // Line fetch towards main memory; the address is always line aligned.
    typedef struct packed {
        logic [addr_width-1:0] addr;
    } mem_req_t;

    // Whole line returned by main memory.
    typedef struct packed {
        logic [line_bits-1:0] line;
    } mem_fill_t;

    // Refill controller states.
    typedef enum logic [1:0] {
        idle      = 2'd0,  // Ready for a new request.
        lookup    = 2'd1,  // Tag compare on the held request.
        wait_fill = 2'd2,  // Line fetch outstanding.
        replay    = 2'd3   // Lookup again after the line is written.
    } ctrl_state_e;

endpackage

// ==== rtl/cache_cfg_pkg.sv ====
package cache_cfg_pkg;

    localparam int addr_width   = 32;  // Byte address.
    localparam int tag_width    = 24;
    localparam int index_width  = 4;
    localparam int offset_width = 4;

    localparam int way_num  = 4;
    localparam int line_num = 16;  // Sets per way.

    localparam int line_bits = 128;
    localparam int word_bits = 32;

    // Ages run from 0 for the most recent way up to way_num - 1 for the oldest.
    localparam int age_width = $clog2(way_num);
    localparam logic [age_width-1:0] age_max = age_width'(way_num - 1);

    // Victim way for a refill.
    typedef enum logic [2:0] {
        way0   = 3'd0,
        way1   = 3'd1,
        way2   = 3'd2,
        way3   = 3'd3,
        no_way = 3'd4  // No refill target chosen.
    } replace_way_e;

endpackage
